/* all.f */
hw/dprx_msa_pkg.sv
hw/msa_lane_buffer.sv
hw/msa_read_mux.sv
hw/msa_irq_ctrl.sv
hw/dprx_msa_top.sv
tests/dprx_msa_asserts.sv
tests/tb_dprx_msa.sv

/* run.sh */
#!/usr/bin/env bash
# Compile and run the MSA capture simulation with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_dprx_msa \
    -f all.f \
    -o sim_dprx_msa

status=0
sim_out=$(./obj_dir/sim_dprx_msa 2>&1) || status=$?
echo "$sim_out"

if grep -qx "TEST PASSED" <<< "$sim_out"; then
    exit 0
fi

echo "Simulation did not pass (exit status $status)"
exit 1

/* tests/tb_dprx_msa.sv */
// ##############################
// Testbench for the DP RX MSA capture
// Link stimulus, reference model, response and pass-through checks
// ##############################

`timescale 1ns/1ps

module tb_dprx_msa
    import dprx_msa_pkg::*;
();

    logic           CLK_IN;
    logic           rst;
    logic [1:0]     lanes;
    lnk_t           lnk_snk;
    lnk_t           lnk_src;
    msa_req_t       req;
    msa_rsp_t       rsp;
    logic           irq;

    logic [SYM_W-1:0]   sent_q [NUM_LANES][$];  // Bytes of the current packet per lane
    logic [WORD_W-1:0]  exp_q [$];              // Words still owed by the DUT
    logic               strobe_d;               // Strobe of the previous cycle
    int unsigned        cyc_cnt;

    dprx_msa_top dut_i
    (
        .CLK_IN     (CLK_IN),
        .rst        (rst),
        .lanes      (lanes),
        .lnk_snk    (lnk_snk),
        .lnk_src    (lnk_src),
        .req        (req),
        .rsp        (rsp),
        .irq        (irq)
    );

    always #10 CLK_IN = ~CLK_IN;

    task automatic report_failure(input string msg);
        $display("%s", msg);
        $display("TEST FAILED");
        $fatal(1);
    endtask

    task automatic check_value(input string name, input logic [127:0] got,
                               input logic [127:0] exp);
        if (got !== exp)
            report_failure($sformatf("** Error at %0d ns: %s = 0x%0h, expected 0x%0h",
                                     $time, name, got, exp));
    endtask

    // Link as it must leave the DUT
    function automatic lnk_t strip_msa(input lnk_t lnk);
        lnk_t s;
        s = lnk;
        for (int i = 0; i < NUM_LANES; i++)
        begin
            s.lane[i].msa = '0;
            s.lane[i].sec = '0;
        end
        return s;
    endfunction

    function automatic int active_lanes(input logic [1:0] mode);
        case (mode)
            LANES_4 : return 4;
            LANES_2 : return 2;
            default : return 1;
        endcase
    endfunction

    function automatic int word_count(input logic [1:0] mode, input int len);
        case (mode)
            LANES_4 : return 2 * len;
            LANES_2 : return len;
            default : return len / 2;
        endcase
    endfunction

    // Random lane traffic with no MSA symbols
    function automatic lnk_lane_t idle_lane();
        logic [31:0]    r;
        lnk_lane_t      l;
        r = $urandom;
        l = r[$bits(lnk_lane_t)-1:0];
        l.msa = '0;
        return l;
    endfunction

    // Expected word k with the first named lane in the upper byte
    function automatic logic [WORD_W-1:0] ref_word(input logic [1:0] mode, input int k);
        int hi;
        case (mode)
            LANES_4 :
            begin
                hi = (k % 4 == 0 || k % 4 == 2) ? 0 : 2;
                return {sent_q[hi][k / 2], sent_q[hi + 1][k / 2]};
            end
            LANES_2 : return {sent_q[0][k], sent_q[1][k]};
            default : return {sent_q[0][2 * k], sent_q[0][2 * k + 1]};
        endcase
    endfunction

    // One packet of len bytes on every lane
    // Phase bit i delays lane i by one symbol
    task automatic send_packets(input logic [1:0] mode, input int len,
                                input logic [NUM_LANES-1:0] phase, input logic lock_val);
        int     last_eop;   // Eop cycle of the latest active lane
        int     span;
        int     n;
        int     pos;
        lnk_t   lnk;
        last_eop = 0;
        span     = 0;
        for (int i = 0; i < NUM_LANES; i++)
        begin
            sent_q[i].delete();
            for (int b = 0; b < len; b++)
                sent_q[i].push_back(SYM_W'($urandom));
            n = (len + int'(phase[i]) + 1) / 2;     // Also the index of the eop cycle
            if (n > span)
                span = n;
            if (i < active_lanes(mode) && n > last_eop)
                last_eop = n;
        end
        for (int c = 0; c < span + 3; c++)
        begin
            @(negedge CLK_IN);
            // Flags set at the eop edge and irq one edge later
            check_value("irq", irq, lock_val && (c >= last_eop + 2));
            lnk.lock = lock_val;
            for (int i = 0; i < NUM_LANES; i++)
            begin
                lnk.lane[i] = idle_lane();
                for (int s = 0; s < SPL; s++)
                begin
                    pos = SPL * c + s - int'(phase[i]);
                    if (pos >= 0 && pos < len)
                    begin
                        lnk.lane[i].msa[s] = 1'b1;
                        lnk.lane[i].dat[s] = sent_q[i][pos];
                    end
                end
            end
            lnk_snk = lnk;
        end
    endtask

    task automatic read_packet(input logic [1:0] mode, input int nwords);
        int t;
        for (int k = 0; k < nwords; k++)
        begin
            @(negedge CLK_IN);
            check_value("irq", irq, k == 0);    // Drops one cycle after the first strobe
            req.strobe = 1'b1;
            req.first  = (k == 0);
            req.idx    = IDX_W'(k);
            exp_q.push_back(ref_word(mode, k));
            if ($urandom_range(0, 3) == 0)
            begin
                @(negedge CLK_IN);
                req = '0;
                check_value("irq", irq, 1'b0);
            end
        end
        @(negedge CLK_IN);
        req = '0;
        check_value("irq", irq, 1'b0);
        t = 0;
        while (exp_q.size() != 0 && t < 20)
        begin
            @(negedge CLK_IN);
            t++;
        end
        if (exp_q.size() != 0)
            report_failure("Timeout while waiting for read responses");
    endtask

    task automatic run_packet(input logic [1:0] mode, input int len,
                              input logic [NUM_LANES-1:0] phase);
        lanes = mode;
        send_packets(mode, len, phase, 1'b1);
        read_packet(mode, word_count(mode, len));
    endtask

    always @(posedge CLK_IN)
    begin
        cyc_cnt  <= cyc_cnt + 1;
        strobe_d <= req.strobe;
    end

    // Pass-through holds in every cycle
    always @(posedge CLK_IN)
        check_value("lnk_src", lnk_src, strip_msa(lnk_snk));

    always @(negedge CLK_IN)
    begin
        if (cyc_cnt != 0)
        begin
            check_value("rsp.vld", rsp.vld, strobe_d);
            if (rsp.vld)
            begin
                if (exp_q.size() == 0)
                    report_failure("Read response arrived with no word outstanding");
                else
                    check_value("rsp.dat", rsp.dat, exp_q.pop_front());
            end
        end
    end

    initial
    begin
        void'($urandom(32'ha3a8));
        CLK_IN       = 1'b0;
        rst          = 1'b1;
        lanes        = LANES_4;
        lnk_snk      = '0;
        lnk_snk.lock = 1'b1;
        req          = '0;
        strobe_d     = 1'b0;
        cyc_cnt      = 0;
        repeat (4) @(negedge CLK_IN);
        rst = 1'b0;

        repeat (3) run_packet(LANES_4, $urandom_range(2, 16), 4'b0000);
        // Lanes mixed in phase 0 and phase 1
        repeat (3) run_packet(LANES_4, $urandom_range(2, 16), NUM_LANES'($urandom));
        run_packet(LANES_4, $urandom_range(2, 16), 4'b1111);
        repeat (2) run_packet(LANES_2, $urandom_range(2, 32), NUM_LANES'($urandom));
        repeat (2) run_packet(LANES_1, 2 * $urandom_range(1, 32), NUM_LANES'($urandom));

        // No interrupt without lock and normal capture afterwards
        lanes = LANES_4;
        send_packets(LANES_4, 8, 4'b0101, 1'b0);
        run_packet(LANES_4, $urandom_range(2, 16), NUM_LANES'($urandom));

        $display("TEST PASSED");
        $finish;
    end

endmodule

/* tests/dprx_msa_asserts.sv */
// ##############################
// Bound assertions on the MSA capture top level
// ##############################

`timescale 1ns/1ps

module dprx_msa_asserts
    import dprx_msa_pkg::*;
(
    input  logic        CLK_IN,
    input  logic        rst,
    input  lnk_t        lnk_snk,
    input  msa_req_t    req,
    input  msa_rsp_t    rsp,
    input  logic        irq
);

    // Every strobe answered one cycle later
    vld_after_strobe : assert property (
        @(posedge CLK_IN) disable iff (rst)
        req.strobe |=> rsp.vld
    ) else $error("rsp.vld missing one cycle after a read strobe");

    vld_needs_strobe : assert property (
        @(posedge CLK_IN) disable iff (rst)
        rsp.vld |-> $past(req.strobe)
    ) else $error("rsp.vld without a read strobe in the cycle before");

    irq_needs_lock : assert property (
        @(posedge CLK_IN) disable iff (rst)
        !lnk_snk.lock |=> !irq
    ) else $error("irq high while lock is low");

    irq_after_reset : assert property (
        @(posedge CLK_IN)
        rst |=> !irq
    ) else $error("irq high in the cycle after reset");

endmodule

bind dprx_msa_top dprx_msa_asserts asserts_i (.*);

/* hw/dprx_msa_top.sv */
// ##############################
// DP RX MSA capture top level
// Lane buffers, read mux, interrupt and link pass-through
// ##############################

`timescale 1ns/1ps

module dprx_msa_top
    import dprx_msa_pkg::*;
(
    input  logic        CLK_IN,
    input  logic        rst,
    input  logic [1:0]  lanes,      // Must stay static during a packet
    input  lnk_t        lnk_snk,
    output lnk_t        lnk_src,
    input  msa_req_t    req,
    output msa_rsp_t    rsp,
    output logic        irq
);

    logic [NUM_LANES-1:0][SPL-1:0][SYM_W-1:0]   lane_dat;
    logic [NUM_LANES-1:0][SPL-1:0]              lane_rd;
    logic [NUM_LANES-1:0]                       lane_eop;

    // Stream passes on without MSA and secondary packets
    always_comb
    begin
        lnk_src = lnk_snk;
        for (int i = 0; i < NUM_LANES; i++)
        begin
            lnk_src.lane[i].msa = '0;
            lnk_src.lane[i].sec = '0;
        end
    end

    for (genvar i = 0; i < NUM_LANES; i++)
    begin : gen_lane
        msa_lane_buffer lane_buf_i
        (
            .CLK_IN     (CLK_IN),
            .rst        (rst),
            .lane_in    (lnk_snk.lane[i]),
            .rd         (lane_rd[i]),
            .dat        (lane_dat[i]),
            .eop        (lane_eop[i])
        );
    end

    msa_read_mux read_mux_i
    (
        .CLK_IN     (CLK_IN),
        .rst        (rst),
        .lanes      (lanes),
        .req        (req),
        .lane_dat   (lane_dat),
        .lane_rd    (lane_rd),
        .rsp        (rsp)
    );

    msa_irq_ctrl irq_ctrl_i
    (
        .CLK_IN     (CLK_IN),
        .rst        (rst),
        .lanes      (lanes),
        .lock       (lnk_snk.lock),
        .eop        (lane_eop),
        .req        (req),
        .irq        (irq)
    );

endmodule

/* hw/msa_irq_ctrl.sv */
// ##############################
// Per-lane packet done flags and MSA interrupt
// ##############################

`timescale 1ns/1ps

module msa_irq_ctrl
    import dprx_msa_pkg::*;
(
    input  logic                    CLK_IN,
    input  logic                    rst,
    input  logic [1:0]              lanes,
    input  logic                    lock,
    input  logic [NUM_LANES-1:0]    eop,
    input  msa_req_t                req,
    output logic                    irq
);

    logic [NUM_LANES-1:0]   done;       // Sticky end of packet per lane
    logic                   all_done;

    always_comb
    begin
        case (lanes)
            LANES_4 : all_done = &done;
            LANES_2 : all_done = &done[1:0];
            LANES_1 : all_done = done[0];
            default : all_done = 1'b0;
        endcase
    end

    always_ff @(posedge CLK_IN)
    begin
        if (rst || !lock)
            done <= '0;
        else if (irq)
            done <= '0;     // Rearm for the next packet
        else
            done <= done | eop;
    end

    always_ff @(posedge CLK_IN)
    begin
        if (rst || !lock)
            irq <= 1'b0;
        else if (req.strobe && req.first)
            irq <= 1'b0;
        else if (all_done)
            irq <= 1'b1;
    end

endmodule

/* hw/msa_read_mux.sv */
// ##############################
// Word index decode and response register
// ##############################

`timescale 1ns/1ps

module msa_read_mux
    import dprx_msa_pkg::*;
(
    input  logic                                        CLK_IN,
    input  logic                                        rst,
    input  logic [1:0]                                  lanes,
    input  msa_req_t                                    req,
    input  logic [NUM_LANES-1:0][SPL-1:0][SYM_W-1:0]    lane_dat,
    output logic [NUM_LANES-1:0][SPL-1:0]               lane_rd,
    output msa_rsp_t                                    rsp
);

    logic [LANE_W-1:0]  hi_lane;    // Upper byte source
    logic [SUB_W-1:0]   hi_sub;
    logic [LANE_W-1:0]  lo_lane;    // Lower byte source
    logic [SUB_W-1:0]   lo_sub;
    logic               vld_q;
    logic [WORD_W-1:0]  dat_q;

    // Word index to lane and sublane positions
    always_comb
    begin
        case (lanes)
            LANES_4 :
            begin
                // Lanes 0 and 1 on even words, 2 and 3 on odd words
                hi_lane = {req.idx[0], 1'b0};
                lo_lane = {req.idx[0], 1'b1};
                hi_sub  = SUB_W'(req.idx[1]);
                lo_sub  = SUB_W'(req.idx[1]);
            end

            LANES_2 :
            begin
                hi_lane = LANE_W'(0);
                lo_lane = LANE_W'(1);
                hi_sub  = SUB_W'(req.idx[0]);
                lo_sub  = SUB_W'(req.idx[0]);
            end

            default :
            begin
                // Single lane, both bytes from lane 0
                hi_lane = LANE_W'(0);
                lo_lane = LANE_W'(0);
                hi_sub  = SUB_W'(0);
                lo_sub  = SUB_W'(1);
            end
        endcase
    end

    // Read strobes advance the pointers at the same edge the word is taken
    always_comb
    begin
        lane_rd = '0;
        if (req.strobe)
        begin
            lane_rd[hi_lane][hi_sub] = 1'b1;
            lane_rd[lo_lane][lo_sub] = 1'b1;
        end
    end

    always_ff @(posedge CLK_IN)
    begin
        if (rst)
            vld_q <= 1'b0;
        else
            vld_q <= req.strobe;
    end

    always_ff @(posedge CLK_IN)
    begin
        if (req.strobe)
            dat_q <= {lane_dat[hi_lane][hi_sub], lane_dat[lo_lane][lo_sub]};
    end

    assign rsp = '{vld: vld_q, dat: dat_q};

endmodule

/* hw/msa_lane_buffer.sv */
// ##############################
// MSA capture buffer for one link lane
// Sublane RAMs, pointers, packet edges and phase alignment
// ##############################

`timescale 1ns/1ps

module msa_lane_buffer
    import dprx_msa_pkg::*;
(
    input  logic                        CLK_IN,
    input  logic                        rst,
    input  lnk_lane_t                   lane_in,
    input  logic [SPL-1:0]              rd,     // Read strobes, aligned order
    output logic [SPL-1:0][SYM_W-1:0]   dat,    // Read data, aligned order
    output logic                        eop
);

    logic               msa_any;
    logic               msa_any_q;      // Previous cycle had MSA symbols
    logic               sop;
    logic [SUB_W-1:0]   ph;             // Sublane of the first MSA byte
    logic [SPL-1:0]     ram_rd;         // Read strobes, physical order
    logic [SYM_W-1:0]   dout [SPL];     // Read data, physical order

    // Packet edges from the MSA flags
    assign msa_any = |lane_in.msa;
    assign sop     = msa_any && !msa_any_q;
    assign eop     = !msa_any && msa_any_q;

    always_ff @(posedge CLK_IN)
    begin
        if (rst)
            msa_any_q <= 1'b0;
        else
            msa_any_q <= msa_any;
    end

    // Phase is taken from the first cycle of the packet
    always_ff @(posedge CLK_IN)
    begin
        if (rst)
            ph <= '0;
        else if (sop)
        begin
            if (lane_in.msa == SPL'(2))
                ph <= SUB_W'(1);    // Starts on sublane 1
            else
                ph <= '0;
        end
    end

    for (genvar j = 0; j < SPL; j++)
    begin : gen_sub
        logic [SYM_W-1:0]       ram [RAM_WORDS];
        logic [RAM_ADR_W-1:0]   wp;
        logic [RAM_ADR_W-1:0]   rp;

        always_ff @(posedge CLK_IN)
        begin
            if (lane_in.msa[j])
                ram[wp] <= lane_in.dat[j];
        end

        // Write pointer restarts whenever the sublane is idle
        always_ff @(posedge CLK_IN)
        begin
            if (rst || !lane_in.msa[j])
                wp <= '0;
            else
                wp <= wp + 1'b1;
        end

        always_ff @(posedge CLK_IN)
        begin
            if (rst || eop)
                rp <= '0;
            else if (ram_rd[j])
                rp <= rp + 1'b1;
        end

        assign dout[j] = ram[rp];   // Asynchronous read
    end

    // Rotate back into arrival order
    // Aligned sublane k lives in physical sublane k + ph
    always_comb
    begin
        ram_rd = '0;
        for (int k = 0; k < SPL; k++)
        begin
            dat[k]                        = dout[(k + int'(ph)) % SPL];
            ram_rd[(k + int'(ph)) % SPL]  = rd[k];
        end
    end

endmodule

/* hw/dprx_msa_pkg.sv */
// ##############################
// Shared constants and types for the DP RX MSA capture
// Link lane, link, read request and read response structs
// ##############################

package dprx_msa_pkg;

    // Link geometry
    localparam int NUM_LANES = 4;
    localparam int SPL       = 2;   // Symbols per lane per clock
    localparam int SYM_W     = 8;

    // Index widths for lanes and sublanes
    localparam int LANE_W = $clog2(NUM_LANES);
    localparam int SUB_W  = $clog2(SPL);

    // Sublane RAM sizing
    localparam int RAM_WORDS = 32;
    localparam int RAM_ADR_W = 5;

    // Read port
    localparam int IDX_W  = 5;
    localparam int WORD_W = 16;

    // Lane control codes
    localparam logic [1:0] LANES_1 = 2'd1;
    localparam logic [1:0] LANES_2 = 2'd2;
    localparam logic [1:0] LANES_4 = 2'd3;

    // One lane for one clock
    // Bit j of every flag field belongs to sublane j
    typedef struct packed {
        logic [SPL-1:0]             sol;    // Start of line
        logic [SPL-1:0]             eol;    // End of line
        logic [SPL-1:0]             vid;    // Video data
        logic [SPL-1:0]             sec;    // Secondary packet
        logic [SPL-1:0]             msa;    // Main stream attributes
        logic [SPL-1:0]             vbid;   // VB-ID
        logic [SPL-1:0]             k;      // Control symbol
        logic [SPL-1:0][SYM_W-1:0]  dat;
    } lnk_lane_t;

    // Whole receive link
    typedef struct packed {
        logic                           lock;
        lnk_lane_t [NUM_LANES-1:0]      lane;
    } lnk_t;

    // Read request, single cycle strobe
    typedef struct packed {
        logic               strobe;
        logic               first;  // First word of a readout, clears the interrupt
        logic [IDX_W-1:0]   idx;    // Word index
    } msa_req_t;

    // Read response, one cycle after the strobe
    typedef struct packed {
        logic               vld;
        logic [WORD_W-1:0]  dat;
    } msa_rsp_t;

endpackage
